//--- build.f
dbg_cfg_pkg.sv
dbg_types_pkg.sv
uart_tx.sv
uart_rx.sv
debug_streamer.sv
debug_regs.sv
debug_monitor_top.sv
tb_debug_monitor.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the debug monitor testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module tb_debug_monitor \
        -o tb_debug_monitor \
    && ./obj_dir/tb_debug_monitor > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
! grep -q "SIMULATION FAILED" sim.log \
    && grep -q "SIMULATION PASSED" sim.log \
    || { echo "test failed, see sim.log"; exit 1; }

//--- tb_debug_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_debug_monitor;

    localparam int TICKS = dbg_cfg_pkg::TICKS_PER_BIT;
    localparam int STREAM_PERIOD = 48;
    localparam int FRAME_BYTES = dbg_cfg_pkg::BYTES_PER_WORD + 1;
    localparam int FRAME_CYCLES = FRAME_BYTES * 10 * TICKS;
    localparam int NUM_FRAMES = 6;
    localparam int APB_TIMEOUT = 8;
    localparam logic [31:0] LFSR_TAPS = 32'hB4BC_D35C;

    logic clk_in = 1'b0;
    logic reset;
    logic i_psel;
    logic i_penable;
    logic i_pwrite;
    dbg_types_pkg::apb_addr_t i_paddr;
    dbg_types_pkg::apb_data_t i_pwdata;
    dbg_types_pkg::apb_data_t o_prdata;
    logic o_pready;
    logic o_pslverr;
    dbg_types_pkg::word_t i_data;
    logic i_rx;
    logic o_tx;
    logic o_busy;

    logic [31:0] lfsr_q;
    int errors;
    int checks;

    debug_monitor_top uut (
        .clk_in    (clk_in),
        .reset     (reset),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .i_data    (i_data),
        .i_rx      (i_rx),
        .o_tx      (o_tx),
        .o_busy    (o_busy)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one lfsr step per random bit
    task automatic take_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value[i] = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // setup phase, then access phase until pready
    task automatic apb_access(input logic write, input dbg_types_pkg::apb_addr_t addr,
                              input dbg_types_pkg::apb_data_t wdata,
                              output dbg_types_pkg::apb_data_t rdata, output logic slverr);
        int waited;
        @(posedge clk_in);
        #5;
        i_psel = 1'b1;
        i_penable = 1'b0;
        i_pwrite = write;
        i_paddr = addr;
        i_pwdata = wdata;
        @(posedge clk_in);
        #5;
        i_penable = 1'b1;
        waited = 0;
        @(negedge clk_in);
        while (!o_pready && waited < APB_TIMEOUT) begin
            @(negedge clk_in);
            waited++;
        end
        assert (o_pready) else begin
            errors++;
            $display("APB access to offset 0x%0h never completed", addr);
        end
        rdata = o_prdata;
        slverr = o_pslverr;
        @(posedge clk_in);
        #5;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
    endtask

    task automatic apb_write(input dbg_types_pkg::apb_addr_t addr,
                             input dbg_types_pkg::apb_data_t wdata);
        dbg_types_pkg::apb_data_t rdata;
        logic slverr;
        apb_access(1'b1, addr, wdata, rdata, slverr);
        check_equal("o_pslverr", 32'(slverr), 32'd0);
    endtask

    task automatic apb_read(input dbg_types_pkg::apb_addr_t addr,
                            output dbg_types_pkg::apb_data_t rdata);
        logic slverr;
        apb_access(1'b0, addr, '0, rdata, slverr);
        check_equal("o_pslverr", 32'(slverr), 32'd0);
    endtask

    task automatic wait_busy(input logic level, input int max_cycles);
        int waited;
        waited = 0;
        @(negedge clk_in);
        while (o_busy !== level && waited < max_cycles) begin
            @(negedge clk_in);
            waited++;
        end
        assert (o_busy === level) else begin
            errors++;
            $display("o_busy did not go to %0d within %0d cycles", level, max_cycles);
        end
    endtask

    // serial decoder samples o_tx in the middle of each bit
    task automatic decode_byte(input int max_wait, output dbg_types_pkg::byte_t value);
        int waited;
        int i;
        value = '0;
        waited = 0;
        @(negedge clk_in);
        while (o_tx !== 1'b0 && waited < max_wait) begin
            @(negedge clk_in);
            waited++;
        end
        assert (o_tx === 1'b0) else begin
            errors++;
            $display("no start bit on o_tx within %0d cycles", max_wait);
        end
        if (o_tx === 1'b0) begin
            repeat (TICKS / 2) @(negedge clk_in);
            check_equal("o_tx start bit", 32'(o_tx), 32'd0);
            for (i = 0; i < 8; i++) begin
                repeat (TICKS) @(negedge clk_in);
                value[i] = o_tx;
            end
            repeat (TICKS) @(negedge clk_in);
            check_equal("o_tx stop bit", 32'(o_tx), 32'd1);
        end
    endtask

    // word bytes msb first, then the newline
    task automatic decode_frame(input dbg_types_pkg::word_t word);
        dbg_types_pkg::byte_t got;
        dbg_types_pkg::byte_t expected;
        int k;
        for (k = 0; k < FRAME_BYTES; k++) begin
            if (k < dbg_cfg_pkg::BYTES_PER_WORD) begin
                expected = word[(dbg_cfg_pkg::DATA_WIDTH - 1 - 8 * k) -: 8];
            end else begin
                expected = dbg_cfg_pkg::NEWLINE;
            end
            decode_byte((k == 0) ? STREAM_PERIOD + 20 : 20, got);
            check_equal("o_tx byte", 32'(got), 32'(expected));
            check_equal("o_busy", 32'(o_busy), 32'd1);
        end
    endtask

    // 8N1 serial encoder on i_rx
    task automatic send_uart_byte(input dbg_types_pkg::byte_t value);
        int i;
        @(posedge clk_in);
        #5;
        i_rx = 1'b0;
        for (i = 0; i < 8; i++) begin
            repeat (TICKS) @(posedge clk_in);
            #5;
            i_rx = value[i];
        end
        repeat (TICKS) @(posedge clk_in);
        #5;
        i_rx = 1'b1;
        repeat (TICKS) @(posedge clk_in);
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] exp_period;
        dbg_types_pkg::apb_data_t rdata;
        logic slverr;
        dbg_types_pkg::byte_t cmd;
        int low_seen;
        int n;

        reset = 1'b1;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
        i_paddr = '0;
        i_pwdata = '0;
        i_data = '0;
        i_rx = 1'b1;
        lfsr_q = 32'hba0e;
        errors = 0;
        checks = 0;

        repeat (8) @(posedge clk_in);
        #5;
        reset = 1'b0;
        check_equal("o_tx", 32'(o_tx), 32'd1);
        check_equal("o_busy", 32'(o_busy), 32'd0);

        // register defaults and period clamping
        apb_read(dbg_types_pkg::REG_CTRL, rdata);
        check_equal("o_prdata ctrl", rdata, 32'd0);
        apb_read(dbg_types_pkg::REG_PERIOD, rdata);
        check_equal("o_prdata period", rdata, 32'(dbg_cfg_pkg::PERIOD_RESET));
        take_bits(24, rnd);
        exp_period = (rnd < 32'(dbg_cfg_pkg::PERIOD_MIN)) ? 32'(dbg_cfg_pkg::PERIOD_MIN) : rnd;
        apb_write(dbg_types_pkg::REG_PERIOD, rnd);
        apb_read(dbg_types_pkg::REG_PERIOD, rdata);
        check_equal("o_prdata period", rdata, exp_period);
        take_bits(4, rnd);
        apb_write(dbg_types_pkg::REG_PERIOD, rnd);
        apb_read(dbg_types_pkg::REG_PERIOD, rdata);
        check_equal("o_prdata period", rdata, 32'(dbg_cfg_pkg::PERIOD_MIN));

        // valid of a single command clears on read
        take_bits(8, rnd);
        cmd = rnd[7:0];
        send_uart_byte(cmd);
        apb_read(dbg_types_pkg::REG_RXDATA, rdata);
        check_equal("o_prdata rxdata", rdata, {23'd0, 1'b1, cmd});
        apb_read(dbg_types_pkg::REG_RXDATA, rdata);
        check_equal("o_prdata rxdata valid", 32'(rdata[8]), 32'd0);

        // second command overwrites the first and flags overrun
        take_bits(8, rnd);
        send_uart_byte(rnd[7:0]);
        take_bits(8, rnd);
        cmd = rnd[7:0];
        send_uart_byte(cmd);
        apb_read(dbg_types_pkg::REG_STATUS, rdata);
        check_equal("o_prdata status overrun", 32'(rdata[1]), 32'd1);
        apb_read(dbg_types_pkg::REG_RXDATA, rdata);
        check_equal("o_prdata rxdata", rdata, {23'd0, 1'b1, cmd});
        apb_read(dbg_types_pkg::REG_STATUS, rdata);
        check_equal("o_prdata status overrun", 32'(rdata[1]), 32'd0);
        apb_read(dbg_types_pkg::REG_RXDATA, rdata);
        check_equal("o_prdata rxdata valid", 32'(rdata[8]), 32'd0);

        // streaming frames
        apb_write(dbg_types_pkg::REG_PERIOD, 32'(STREAM_PERIOD));
        take_bits(32, rnd);
        @(posedge clk_in);
        #5;
        i_data = rnd;
        apb_write(dbg_types_pkg::REG_CTRL, 32'd1);
        for (n = 0; n < NUM_FRAMES; n++) begin
            fork
                decode_frame(i_data);
                begin
                    wait_busy(1'b1, STREAM_PERIOD + 20);
                    apb_read(dbg_types_pkg::REG_STATUS, rdata);
                    check_equal("o_prdata status busy", 32'(rdata[0]), 32'd1);
                end
            join
            wait_busy(1'b0, 40);
            apb_read(dbg_types_pkg::REG_STATUS, rdata);
            check_equal("o_prdata status busy", 32'(rdata[0]), 32'd0);
            // new word only while the streamer is idle
            if (n < NUM_FRAMES - 1) begin
                take_bits(32, rnd);
                @(posedge clk_in);
                #5;
                i_data = rnd;
            end
        end

        // disabled monitor keeps the line idle
        apb_write(dbg_types_pkg::REG_CTRL, 32'd0);
        low_seen = 0;
        repeat (3 * (STREAM_PERIOD + FRAME_CYCLES)) begin
            @(negedge clk_in);
            if (o_tx !== 1'b1) begin
                low_seen++;
            end
        end
        assert (low_seen == 0) else begin
            errors++;
            $display("o_tx was low for %0d cycles while the monitor was disabled", low_seen);
        end

        // unmapped offset
        apb_access(1'b0, 4'hD, '0, rdata, slverr);
        check_equal("o_pslverr", 32'(slverr), 32'd1);
        check_equal("o_prdata unmapped", rdata, 32'd0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- debug_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module debug_monitor_top (
    input  wire                             clk_in,
    input  wire                             reset,
    input  wire                             i_psel,
    input  wire                             i_penable,
    input  wire                             i_pwrite,
    input  wire dbg_types_pkg::apb_addr_t   i_paddr,
    input  wire dbg_types_pkg::apb_data_t   i_pwdata,
    output dbg_types_pkg::apb_data_t        o_prdata,
    output logic                            o_pready,
    output logic                            o_pslverr,
    input  wire dbg_types_pkg::word_t       i_data,
    input  wire                             i_rx,
    output logic                            o_tx,
    output logic                            o_busy
);

    logic enable;
    dbg_types_pkg::period_t period;
    logic tx_start;
    dbg_types_pkg::byte_t tx_data;
    logic tx_busy;
    dbg_types_pkg::byte_t rx_data;
    logic rx_valid;

    debug_regs u_regs (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .i_rx_data  (rx_data),
        .i_rx_valid (rx_valid),
        .i_busy     (o_busy),
        .o_enable   (enable),
        .o_period   (period)
    );

    debug_streamer u_streamer (
        .clk_in     (clk_in),
        .reset      (reset),
        .i_enable   (enable),
        .i_period   (period),
        .i_data     (i_data),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .o_busy     (o_busy)
    );

    uart_tx u_tx (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_busy  (tx_busy),
        .o_tx    (o_tx)
    );

    uart_rx u_rx (
        .clk_in  (clk_in),
        .reset   (reset),
        .i_rx    (i_rx),
        .o_data  (rx_data),
        .o_valid (rx_valid)
    );

endmodule

`default_nettype wire

//--- debug_regs.sv
`timescale 1ns/1ps
`default_nettype none

module debug_regs (
    input  wire                             clk_in,
    input  wire                             reset,
    input  wire                             i_psel,
    input  wire                             i_penable,
    input  wire                             i_pwrite,
    input  wire dbg_types_pkg::apb_addr_t   i_paddr,
    input  wire dbg_types_pkg::apb_data_t   i_pwdata,
    output dbg_types_pkg::apb_data_t        o_prdata,
    output logic                            o_pready,
    output logic                            o_pslverr,
    input  wire dbg_types_pkg::byte_t       i_rx_data,
    input  wire                             i_rx_valid,
    input  wire                             i_busy,
    output logic                            o_enable,
    output dbg_types_pkg::period_t          o_period
);

    dbg_types_pkg::byte_t cmd_q;
    dbg_types_pkg::period_t wr_period;
    logic valid_q;
    logic overrun_q;
    logic access;
    logic addr_ok;
    logic wr_en;
    logic rd_rx;

    assign access = i_psel && i_penable;
    assign wr_en = access && i_pwrite && addr_ok;
    assign rd_rx = access && !i_pwrite && (i_paddr == dbg_types_pkg::REG_RXDATA);
    assign wr_period = i_pwdata[dbg_cfg_pkg::PERIOD_WIDTH-1:0];

    // no wait states
    assign o_pready = 1'b1;
    assign o_pslverr = access && !addr_ok;

    // read mux, unmapped offsets read as zero
    always_comb begin
        addr_ok = 1'b1;
        o_prdata = '0;
        case (i_paddr)
            dbg_types_pkg::REG_CTRL:   o_prdata = dbg_types_pkg::apb_data_t'(o_enable);
            dbg_types_pkg::REG_PERIOD: o_prdata = dbg_types_pkg::apb_data_t'(o_period);
            dbg_types_pkg::REG_RXDATA: o_prdata = dbg_types_pkg::apb_data_t'({valid_q, cmd_q});
            dbg_types_pkg::REG_STATUS: o_prdata = dbg_types_pkg::apb_data_t'({overrun_q, i_busy});
            default:                   addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            o_enable <= 1'b0;
            o_period <= dbg_cfg_pkg::PERIOD_RESET;
        end else if (wr_en) begin
            if (i_paddr == dbg_types_pkg::REG_CTRL) begin
                o_enable <= i_pwdata[0];
            end
            // too short an interval is raised to the minimum
            if (i_paddr == dbg_types_pkg::REG_PERIOD) begin
                o_period <= (wr_period < dbg_cfg_pkg::PERIOD_MIN) ?
                            dbg_cfg_pkg::PERIOD_MIN : wr_period;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (i_rx_valid) begin
            cmd_q <= i_rx_data;
        end
    end

    // new command wins over a read in the same cycle
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            overrun_q <= 1'b0;
        end else if (i_rx_valid) begin
            valid_q <= 1'b1;
            overrun_q <= !rd_rx && (valid_q || overrun_q);
        end else if (rd_rx) begin
            valid_q <= 1'b0;
            overrun_q <= 1'b0;
        end
    end

    a_penable_needs_psel: assert property (
        @(posedge clk_in) disable iff (reset) !(i_penable && !i_psel)
    );

endmodule

`default_nettype wire

//--- debug_streamer.sv
`timescale 1ns/1ps
`default_nettype none

module debug_streamer (
    input  wire                         clk_in,
    input  wire                         reset,
    input  wire                         i_enable,
    input  wire dbg_types_pkg::period_t i_period,
    input  wire dbg_types_pkg::word_t   i_data,
    input  wire                         i_tx_busy,
    output logic                        o_tx_start,
    output dbg_types_pkg::byte_t        o_tx_data,
    output logic                        o_busy
);

    dbg_types_pkg::stream_state_t state;
    dbg_types_pkg::period_t cnt;
    dbg_types_pkg::word_t word_q;
    logic [dbg_cfg_pkg::BYTE_IDX_WIDTH-1:0] byte_idx;
    logic last_byte;
    logic snap;
    logic issue;

    assign snap = i_enable && (state == dbg_types_pkg::S_IDLE) && (cnt >= i_period);
    assign issue = (state == dbg_types_pkg::S_LOAD) && !i_tx_busy;
    // index past the word selects the newline
    assign last_byte = (byte_idx == dbg_cfg_pkg::LAST_BYTE_IDX);

    // interval counter is held at zero while disabled or sending
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            cnt <= '0;
        end else if (!i_enable || state != dbg_types_pkg::S_IDLE || snap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // snapshot, then peel off the top byte each time one is issued
    always_ff @(posedge clk_in) begin
        if (snap) begin
            word_q <= i_data;
        end else if (issue) begin
            o_tx_data <= last_byte ? dbg_cfg_pkg::NEWLINE : word_q[dbg_cfg_pkg::DATA_WIDTH-1 -: 8];
            word_q <= word_q << 8;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= dbg_types_pkg::S_IDLE;
            byte_idx <= '0;
            o_tx_start <= 1'b0;
            o_busy <= 1'b0;
        end else begin
            case (state)
                dbg_types_pkg::S_IDLE: begin
                    if (snap) begin
                        state <= dbg_types_pkg::S_LOAD;
                        byte_idx <= '0;
                        o_busy <= 1'b1;
                    end
                end
                dbg_types_pkg::S_LOAD: begin
                    if (issue) begin
                        o_tx_start <= 1'b1;
                        state <= dbg_types_pkg::S_SEND;
                    end
                end
                dbg_types_pkg::S_SEND: begin
                    // transmitter raises busy on this edge
                    o_tx_start <= 1'b0;
                    state <= dbg_types_pkg::S_WAIT;
                end
                default: begin
                    if (!i_tx_busy) begin
                        if (last_byte) begin
                            state <= dbg_types_pkg::S_IDLE;
                            o_busy <= 1'b0;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state <= dbg_types_pkg::S_LOAD;
                        end
                    end
                end
            endcase
        end
    end

    // the wait state relies on the transmitter taking the byte right away
    a_start_single_cycle: assert property (
        @(posedge clk_in) disable iff (reset) o_tx_start |=> !o_tx_start && i_tx_busy
    );

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                         clk_in,
    input  wire                         reset,
    input  wire                         i_rx,
    output dbg_types_pkg::byte_t        o_data,
    output logic                        o_valid
);

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    dbg_types_pkg::uart_state_t state;
    logic [dbg_cfg_pkg::TICK_WIDTH-1:0] tick_cnt;
    logic [2:0] bit_cnt;
    dbg_types_pkg::byte_t shift_q;
    logic bit_end;

    // two flop synchronizer plus one stage for edge detect
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // half a bit for the start check, then full bits to land mid-bit
    assign bit_end = (state == dbg_types_pkg::U_START) ?
                     (tick_cnt == dbg_cfg_pkg::TICK_HALF) :
                     (tick_cnt == dbg_cfg_pkg::TICK_LAST);

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (state == dbg_types_pkg::U_IDLE || bit_end) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk_in) begin
        if (state == dbg_types_pkg::U_DATA && bit_end) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == dbg_types_pkg::U_STOP && bit_end && rx_sync) begin
            o_data <= shift_q;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= dbg_types_pkg::U_IDLE;
            bit_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                dbg_types_pkg::U_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state <= dbg_types_pkg::U_START;
                    end
                end
                dbg_types_pkg::U_START: begin
                    // a glitch shorter than half a bit is ignored
                    if (bit_end) begin
                        state <= rx_sync ? dbg_types_pkg::U_IDLE : dbg_types_pkg::U_DATA;
                        bit_cnt <= '0;
                    end
                end
                dbg_types_pkg::U_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= dbg_types_pkg::U_STOP;
                        end
                    end
                end
                default: begin
                    // framing error when the stop bit is low, byte dropped
                    if (bit_end) begin
                        state <= dbg_types_pkg::U_IDLE;
                        o_valid <= rx_sync;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                         clk_in,
    input  wire                         reset,
    input  wire                         i_start,
    input  wire dbg_types_pkg::byte_t   i_data,
    output logic                        o_busy,
    output logic                        o_tx
);

    dbg_types_pkg::uart_state_t state;
    logic [dbg_cfg_pkg::TICK_WIDTH-1:0] tick_cnt;
    logic [2:0] bit_cnt;
    dbg_types_pkg::byte_t shift_q;
    logic bit_end;

    assign bit_end = (tick_cnt == dbg_cfg_pkg::TICK_LAST);

    // tick counter restarts at every bit boundary
    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (state == dbg_types_pkg::U_IDLE || bit_end) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // payload shifts out lsb first
    always_ff @(posedge clk_in) begin
        if (state == dbg_types_pkg::U_IDLE && i_start) begin
            shift_q <= i_data;
        end else if (bit_end && state != dbg_types_pkg::U_STOP) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_ff @(posedge clk_in or posedge reset) begin
        if (reset) begin
            state <= dbg_types_pkg::U_IDLE;
            bit_cnt <= '0;
            o_busy <= 1'b0;
            o_tx <= 1'b1;
        end else begin
            case (state)
                dbg_types_pkg::U_IDLE: begin
                    if (i_start) begin
                        state <= dbg_types_pkg::U_START;
                        o_busy <= 1'b1;
                        o_tx <= 1'b0;
                    end
                end
                dbg_types_pkg::U_START: begin
                    if (bit_end) begin
                        state <= dbg_types_pkg::U_DATA;
                        bit_cnt <= '0;
                        o_tx <= shift_q[0];
                    end
                end
                dbg_types_pkg::U_DATA: begin
                    if (bit_end) begin
                        if (bit_cnt == 3'd7) begin
                            state <= dbg_types_pkg::U_STOP;
                            o_tx <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            o_tx <= shift_q[0];
                        end
                    end
                end
                default: begin
                    // busy drops once the full stop bit is on the line
                    if (bit_end) begin
                        state <= dbg_types_pkg::U_IDLE;
                        o_busy <= 1'b0;
                    end
                end
            endcase
        end
    end

    // the streamer must wait for the previous byte to finish
    a_no_start_when_busy: assert property (
        @(posedge clk_in) disable iff (reset) !(i_start && o_busy)
    );

endmodule

`default_nettype wire

//--- dbg_types_pkg.sv
`default_nettype none

package dbg_types_pkg;

    // uart payload
    typedef logic [7:0] byte_t;

    // word under observation
    typedef logic [dbg_cfg_pkg::DATA_WIDTH-1:0] word_t;

    // snapshot interval count
    typedef logic [dbg_cfg_pkg::PERIOD_WIDTH-1:0] period_t;

    // apb register offset and bus word
    typedef logic [3:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // frame serializer states
    typedef enum logic [1:0] {
        S_IDLE,
        S_LOAD,
        S_SEND,
        S_WAIT
    } stream_state_t;

    // shared by transmitter and receiver
    typedef enum logic [1:0] {
        U_IDLE,
        U_START,
        U_DATA,
        U_STOP
    } uart_state_t;

    // register map
    localparam apb_addr_t REG_CTRL = 4'h0;
    localparam apb_addr_t REG_PERIOD = 4'h4;
    // bits 7..0 command, bit 8 valid
    localparam apb_addr_t REG_RXDATA = 4'h8;
    // bit 0 streamer busy, bit 1 overrun
    localparam apb_addr_t REG_STATUS = 4'hC;

endpackage

`default_nettype wire

//--- dbg_cfg_pkg.sv
`default_nettype none

package dbg_cfg_pkg;

    // observed word, sent most significant byte first
    localparam int DATA_WIDTH = 32;
    localparam int BYTES_PER_WORD = DATA_WIDTH / 8;

    // byte index runs one past the word to cover the newline
    localparam int BYTE_IDX_WIDTH = $clog2(BYTES_PER_WORD + 1);
    localparam logic [BYTE_IDX_WIDTH-1:0] LAST_BYTE_IDX = BYTE_IDX_WIDTH'(BYTES_PER_WORD);

    // uart bit time in clocks, short for simulation (silicon uses 191)
    localparam int TICKS_PER_BIT = 16;
    localparam int TICK_WIDTH = $clog2(TICKS_PER_BIT);
    localparam logic [TICK_WIDTH-1:0] TICK_LAST = TICK_WIDTH'(TICKS_PER_BIT - 1);
    // receiver checks the start bit halfway in
    localparam logic [TICK_WIDTH-1:0] TICK_HALF = TICK_WIDTH'(TICKS_PER_BIT / 2 - 1);

    // snapshot interval
    localparam int PERIOD_WIDTH = 24;
    localparam logic [PERIOD_WIDTH-1:0] PERIOD_RESET = 24'd2000;
    localparam logic [PERIOD_WIDTH-1:0] PERIOD_MIN = 24'd16;

    // frame terminator
    localparam logic [7:0] NEWLINE = 8'h0A;

endpackage

`default_nettype wire
